/* Bender.yml */
package:
  name: mem_subsys

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_cfg.sv
      - lsu.sv
      - dmem.sv
      - load_align.sv
      - remote_req_fifo.sv
      - mem_subsys_top.sv
      - target: simulation
        files:
          - tb_mem_subsys.sv

/* dmem.sv */
// **************************************************
// local data memory
// byte-masked writes, registered reads, one
// load-reserved reservation
// **************************************************
`timescale 1ns/1ns
`include "lsu_settings.svh"

module dmem (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                v_i,
  input  logic                w_i,
  input  lsu_pkg::dmem_addr_t addr_i,
  input  lsu_pkg::word_t      data_i,
  input  lsu_pkg::mask_t      mask_i,
  input  logic                reserve_i,
  output lsu_pkg::word_t      data_o,
  output logic                reserve_valid_o
);
  import lsu_pkg::*;

  word_t      mem [`LSU_DMEM_WORDS];
  word_t      rdata_q;
  dmem_addr_t reserve_addr_q;
  logic       reserve_valid_q;

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      if (w_i) begin
        for (int b = 0; b < $bits(mask_t); b++) begin
          if (mask_i[b]) begin
            mem[addr_i][8*b +: 8] <= data_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  // lr arms the reservation, a store to that word kills it
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      reserve_valid_q <= 1'b0;
    end else if (v_i && reserve_i) begin
      reserve_valid_q <= 1'b1;
      reserve_addr_q  <= addr_i;
    end else if (v_i && w_i && (addr_i == reserve_addr_q)) begin
      reserve_valid_q <= 1'b0;
    end
  end

  assign data_o          = rdata_q;
  assign reserve_valid_o = reserve_valid_q;

endmodule

/* files.f */
+incdir+.
lsu_pkg.sv
lsu_cfg.sv
lsu.sv
dmem.sv
load_align.sv
remote_req_fifo.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* load_align.sv */
// **************************************************
// local load alignment
// picks the loaded lane and sign or zero extends it
// **************************************************
`timescale 1ns/1ns

module load_align (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic               unsigned_i,
  input  logic [1:0]         byte_sel_i,
  input  lsu_pkg::reg_id_t   rd_i,
  input  lsu_pkg::word_t     rdata_i,
  output logic               load_valid_o,
  output lsu_pkg::word_t     load_data_o,
  output lsu_pkg::reg_id_t   load_rd_o
);
  import lsu_pkg::*;

  logic       valid_q;
  mem_size_e  size_q;
  logic       unsigned_q;
  logic [1:0] byte_sel_q;
  reg_id_t    rd_q;
  logic [7:0] byte_lane;
  logic [15:0] half_lane;

  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= start_i;
    end
  end

  // load fields wait here for the memory read
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      size_q     <= size_i;
      unsigned_q <= unsigned_i;
      byte_sel_q <= byte_sel_i;
      rd_q       <= rd_i;
    end
  end

  assign byte_lane = rdata_i[8*byte_sel_q +: 8];
  assign half_lane = rdata_i[16*byte_sel_q[1] +: 16];

  always_comb begin
    case (size_q)
      SIZE_BYTE: load_data_o = {{($bits(word_t)-8){~unsigned_q & byte_lane[7]}}, byte_lane};
      SIZE_HALF: load_data_o = {{($bits(word_t)-16){~unsigned_q & half_lane[15]}}, half_lane};
      default:   load_data_o = rdata_i;
    endcase
  end

  assign load_valid_o = valid_q;
  assign load_rd_o    = rd_q;

endmodule

/* lsu.sv */
// **************************************************
// load/store unit
// address generation, local/remote routing,
// store lane replication and remote request forming
// **************************************************
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu (
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  lsu_pkg::mem_op_e      op_i,
  input  lsu_pkg::mem_size_e    size_i,
  input  logic                  unsigned_i,
  input  lsu_pkg::word_t        rs1_i,
  input  lsu_pkg::word_t        rs2_i,
  input  lsu_pkg::imm_t         offset_i,
  input  lsu_pkg::reg_id_t      rd_i,
  input  logic                  icache_miss_i,
  input  lsu_pkg::word_t        pc_plus4_i,
  input  lsu_pkg::word_t        dram_prefix_i,
  input  logic                  remote_en_i,
  input  logic                  fifo_ready_i,
  output logic                  dmem_v_o,
  output logic                  dmem_w_o,
  output lsu_pkg::dmem_addr_t   dmem_addr_o,
  output lsu_pkg::word_t        dmem_data_o,
  output lsu_pkg::mask_t        dmem_mask_o,
  output logic                  reserve_o,
  output logic                  ld_start_o,
  output lsu_pkg::mem_size_e    ld_size_o,
  output logic                  ld_unsigned_o,
  output logic [1:0]            ld_byte_sel_o,
  output lsu_pkg::reg_id_t      ld_rd_o,
  output logic                  remote_v_o,
  output logic                  remote_write_o,
  output logic                  remote_amo_o,
  output lsu_pkg::word_t        remote_addr_o,
  output lsu_pkg::word_t        remote_data_o,
  output lsu_pkg::mask_t        remote_mask_o,
  output lsu_pkg::reg_id_t      remote_rd_o
);
  import lsu_pkg::*;

  localparam int imm_width_lp = $bits(imm_t);

  word_t mem_addr;
  word_t miss_addr;
  word_t store_data;
  mask_t store_mask;
  logic  is_local;
  logic  is_load;
  logic  is_store;
  logic  is_lr;
  logic  is_amo;
  logic  local_go;
  logic  remote_want;
  logic  remote_go;

  assign mem_addr  = rs1_i + {{(`LSU_DATA_WIDTH-imm_width_lp){offset_i[imm_width_lp-1]}},
                              offset_i};
  assign miss_addr = (pc_plus4_i - word_t'(4)) | dram_prefix_i;
  assign is_local  = ~|mem_addr[`LSU_DATA_WIDTH-1:`LSU_LOCAL_BITS];

  assign is_load  = (op_i == MEM_LOAD);
  assign is_store = (op_i == MEM_STORE);
  assign is_lr    = (op_i == MEM_LR);
  assign is_amo   = (op_i == MEM_AMO);

  // replicate the store value into every lane, mask picks the lanes
  always_comb begin
    store_data = rs2_i;
    store_mask = '1;
    if (!is_amo) begin
      case (size_i)
        SIZE_BYTE: begin
          store_data = {($bits(word_t)/8){rs2_i[7:0]}};
          store_mask = mask_t'(1) << mem_addr[1:0];
        end
        SIZE_HALF: begin
          store_data = {($bits(word_t)/16){rs2_i[15:0]}};
          store_mask = mem_addr[1] ? mask_t'(4'b1100) : mask_t'(4'b0011);
        end
        default: ;
      endcase
    end
  end

  // local amo and remote lr fall through both paths and are dropped
  assign local_go    = req_valid_i & ~icache_miss_i & is_local & (is_load | is_store | is_lr);
  assign remote_want = icache_miss_i | (~is_local & (is_load | is_store | is_amo));
  assign remote_go   = remote_want & remote_en_i;

  // only a remote push can stall
  assign req_ready_o = ~remote_go | fifo_ready_i;

  assign dmem_v_o    = local_go;
  assign dmem_w_o    = is_store;
  assign dmem_addr_o = mem_addr[2 +: $bits(dmem_addr_t)];
  assign dmem_data_o = store_data;
  assign dmem_mask_o = store_mask;
  assign reserve_o   = local_go & is_lr;

  assign ld_start_o    = local_go & (is_load | is_lr);
  assign ld_size_o     = size_i;
  assign ld_unsigned_o = unsigned_i;
  assign ld_byte_sel_o = mem_addr[1:0];
  assign ld_rd_o       = rd_i;

  // fetch on icache miss wins over the data op
  assign remote_v_o     = req_valid_i & remote_go;
  assign remote_write_o = ~icache_miss_i & is_store;
  assign remote_amo_o   = ~icache_miss_i & is_amo;
  assign remote_addr_o  = icache_miss_i ? miss_addr : mem_addr;
  assign remote_data_o  = store_data;
  assign remote_mask_o  = icache_miss_i ? '1 : store_mask;
  assign remote_rd_o    = rd_i;

endmodule

/* lsu_cfg.sv */
// **************************************************
// memory slice configuration registers
// dram prefix for fetches and the remote enable bit
// **************************************************
`timescale 1ns/1ns

module lsu_cfg (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           cfg_we_i,
  input  logic           cfg_sel_i,
  input  lsu_pkg::word_t cfg_data_i,
  output lsu_pkg::word_t dram_prefix_o,
  output logic           remote_en_o
);
  import lsu_pkg::*;

  localparam word_t prefix_reset_lp = 32'h8000_0000;

  word_t prefix_q;
  logic  remote_en_q;

  // sel low picks the prefix, sel high the enable bit
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      prefix_q    <= prefix_reset_lp;
      remote_en_q <= 1'b1;
    end else if (cfg_we_i) begin
      if (cfg_sel_i) begin
        remote_en_q <= cfg_data_i[0];
      end else begin
        prefix_q <= cfg_data_i;
      end
    end
  end

  assign dram_prefix_o = prefix_q;
  assign remote_en_o   = remote_en_q;

endmodule

/* lsu_pkg.sv */
// **************************************************
// memory slice types
// word, mask, id and address types, op and size enums
// **************************************************
`include "lsu_settings.svh"

package lsu_pkg;

  // data or address word
  typedef logic [`LSU_DATA_WIDTH-1:0] word_t;
  // one bit per byte lane
  typedef logic [`LSU_DATA_WIDTH/8-1:0] mask_t;
  // destination register id
  typedef logic [4:0] reg_id_t;
  // word index into local memory
  typedef logic [$clog2(`LSU_DMEM_WORDS)-1:0] dmem_addr_t;
  // signed load/store offset
  typedef logic signed [11:0] imm_t;

  typedef enum logic [1:0] {
    MEM_LOAD,
    MEM_STORE,
    MEM_LR,
    MEM_AMO
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

endpackage

/* lsu_settings.svh */
// **************************************************
// memory slice settings
// widths and depths shared by the memory-access slice
// **************************************************
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define LSU_DATA_WIDTH 32
// local data memory depth in words
`define LSU_DMEM_WORDS 1024
// address is local when all bits from here up are zero
`define LSU_LOCAL_BITS 12
// remote request queue entries
`define LSU_FIFO_DEPTH 2

`endif

/* mem_subsys_top.sv */
// **************************************************
// memory-access slice top
// config, lsu, local memory, load align, remote queue
// **************************************************
`timescale 1ns/1ns

module mem_subsys_top (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  lsu_pkg::mem_op_e   op_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic               unsigned_i,
  input  lsu_pkg::word_t     rs1_i,
  input  lsu_pkg::word_t     rs2_i,
  input  lsu_pkg::imm_t      offset_i,
  input  lsu_pkg::reg_id_t   rd_i,
  input  logic               icache_miss_i,
  input  lsu_pkg::word_t     pc_plus4_i,
  input  logic               cfg_we_i,
  input  logic               cfg_sel_i,
  input  lsu_pkg::word_t     cfg_data_i,
  output logic               load_valid_o,
  output lsu_pkg::word_t     load_data_o,
  output lsu_pkg::reg_id_t   load_rd_o,
  output logic               remote_valid_o,
  input  logic               remote_ready_i,
  output logic               remote_write_o,
  output logic               remote_amo_o,
  output lsu_pkg::word_t     remote_addr_o,
  output lsu_pkg::word_t     remote_data_o,
  output lsu_pkg::mask_t     remote_mask_o,
  output lsu_pkg::reg_id_t   remote_rd_o,
  output logic               reserve_valid_o
);
  import lsu_pkg::*;

  word_t      dram_prefix;
  logic       remote_en;
  logic       fifo_ready;
  logic       dmem_v;
  logic       dmem_w;
  dmem_addr_t dmem_addr;
  word_t      dmem_wdata;
  mask_t      dmem_mask;
  word_t      dmem_rdata;
  logic       reserve;
  logic       ld_start;
  mem_size_e  ld_size;
  logic       ld_unsigned;
  logic [1:0] ld_byte_sel;
  reg_id_t    ld_rd;
  logic       rq_v;
  logic       rq_write;
  logic       rq_amo;
  word_t      rq_addr;
  word_t      rq_data;
  mask_t      rq_mask;
  reg_id_t    rq_rd;

  lsu_cfg i_cfg (
    .clk_i, .reset_i, .cfg_we_i, .cfg_sel_i, .cfg_data_i,
    .dram_prefix_o (dram_prefix),
    .remote_en_o   (remote_en)
  );

  lsu i_lsu (
    .req_valid_i, .req_ready_o, .op_i, .size_i, .unsigned_i, .rs1_i, .rs2_i,
    .offset_i, .rd_i, .icache_miss_i, .pc_plus4_i,
    .dram_prefix_i (dram_prefix),
    .remote_en_i   (remote_en),
    .fifo_ready_i  (fifo_ready),
    .dmem_v_o      (dmem_v),
    .dmem_w_o      (dmem_w),
    .dmem_addr_o   (dmem_addr),
    .dmem_data_o   (dmem_wdata),
    .dmem_mask_o   (dmem_mask),
    .reserve_o     (reserve),
    .ld_start_o    (ld_start),
    .ld_size_o     (ld_size),
    .ld_unsigned_o (ld_unsigned),
    .ld_byte_sel_o (ld_byte_sel),
    .ld_rd_o       (ld_rd),
    .remote_v_o    (rq_v),
    .remote_write_o(rq_write),
    .remote_amo_o  (rq_amo),
    .remote_addr_o (rq_addr),
    .remote_data_o (rq_data),
    .remote_mask_o (rq_mask),
    .remote_rd_o   (rq_rd)
  );

  dmem i_dmem (
    .clk_i, .reset_i,
    .v_i             (dmem_v),
    .w_i             (dmem_w),
    .addr_i          (dmem_addr),
    .data_i          (dmem_wdata),
    .mask_i          (dmem_mask),
    .reserve_i       (reserve),
    .data_o          (dmem_rdata),
    .reserve_valid_o
  );

  load_align i_align (
    .clk_i, .reset_i,
    .start_i    (ld_start),
    .size_i     (ld_size),
    .unsigned_i (ld_unsigned),
    .byte_sel_i (ld_byte_sel),
    .rd_i       (ld_rd),
    .rdata_i    (dmem_rdata),
    .load_valid_o, .load_data_o, .load_rd_o
  );

  remote_req_fifo i_fifo (
    .clk_i, .reset_i,
    .in_valid_i  (rq_v),
    .in_ready_o  (fifo_ready),
    .write_i     (rq_write),
    .amo_i       (rq_amo),
    .addr_i      (rq_addr),
    .data_i      (rq_data),
    .mask_i      (rq_mask),
    .rd_i        (rq_rd),
    .out_valid_o (remote_valid_o),
    .out_ready_i (remote_ready_i),
    .write_o     (remote_write_o),
    .amo_o       (remote_amo_o),
    .addr_o      (remote_addr_o),
    .data_o      (remote_data_o),
    .mask_o      (remote_mask_o),
    .rd_o        (remote_rd_o)
  );

endmodule

/* remote_req_fifo.sv */
// **************************************************
// remote request queue
// small circular buffer of requests toward the network
// **************************************************
`timescale 1ns/1ns
`include "lsu_settings.svh"

module remote_req_fifo (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic             write_i,
  input  logic             amo_i,
  input  lsu_pkg::word_t   addr_i,
  input  lsu_pkg::word_t   data_i,
  input  lsu_pkg::mask_t   mask_i,
  input  lsu_pkg::reg_id_t rd_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic             write_o,
  output logic             amo_o,
  output lsu_pkg::word_t   addr_o,
  output lsu_pkg::word_t   data_o,
  output lsu_pkg::mask_t   mask_o,
  output lsu_pkg::reg_id_t rd_o
);
  import lsu_pkg::*;

  localparam int depth_lp     = `LSU_FIFO_DEPTH;
  localparam int ptr_width_lp = (depth_lp > 1) ? $clog2(depth_lp) : 1;
  localparam int cnt_width_lp = $clog2(depth_lp + 1);

  logic                    write_q [depth_lp];
  logic                    amo_q   [depth_lp];
  word_t                   addr_q  [depth_lp];
  word_t                   data_q  [depth_lp];
  mask_t                   mask_q  [depth_lp];
  reg_id_t                 rd_q    [depth_lp];
  logic [ptr_width_lp-1:0] wr_ptr_q;
  logic [ptr_width_lp-1:0] rd_ptr_q;
  logic [cnt_width_lp-1:0] count_q;
  logic                    push;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    return (ptr == ptr_width_lp'(depth_lp - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != cnt_width_lp'(depth_lp));
  assign out_valid_o = (count_q != '0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      write_q[wr_ptr_q] <= write_i;
      amo_q[wr_ptr_q]   <= amo_i;
      addr_q[wr_ptr_q]  <= addr_i;
      data_q[wr_ptr_q]  <= data_i;
      mask_q[wr_ptr_q]  <= mask_i;
      rd_q[wr_ptr_q]    <= rd_i;
    end
  end

  // push and pop together leave the count alone
  always_ff @(posedge clk_i) begin
    if (!reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  assign write_o = write_q[rd_ptr_q];
  assign amo_o   = amo_q[rd_ptr_q];
  assign addr_o  = addr_q[rd_ptr_q];
  assign data_o  = data_q[rd_ptr_q];
  assign mask_o  = mask_q[rd_ptr_q];
  assign rd_o    = rd_q[rd_ptr_q];

endmodule

/* tb_mem_subsys.sv */
// **************************************************
// memory-access slice testbench
// directed local, remote, icache miss, reservation
// and remote disable tests against a memory model
// **************************************************
`timescale 1ns/1ns
`include "lsu_settings.svh"

module tb_mem_subsys;
  import lsu_pkg::*;

  localparam int clk_period_lp = 4;
  // upper bound on handshakes issued by all tests
  localparam int test_ops_lp   = 64;

  typedef struct packed {
    word_t   addr;
    word_t   data;
    mask_t   mask;
    logic    write;
    logic    amo;
    reg_id_t rd;
  } rreq_t;

  logic      clk_i = 1'b0;
  logic      reset_i;
  logic      req_valid_i;
  logic      req_ready_o;
  mem_op_e   op_i;
  mem_size_e size_i;
  logic      unsigned_i;
  word_t     rs1_i;
  word_t     rs2_i;
  imm_t      offset_i;
  reg_id_t   rd_i;
  logic      icache_miss_i;
  word_t     pc_plus4_i;
  logic      cfg_we_i;
  logic      cfg_sel_i;
  word_t     cfg_data_i;
  logic      load_valid_o;
  word_t     load_data_o;
  reg_id_t   load_rd_o;
  logic      remote_valid_o;
  logic      remote_ready_i;
  logic      remote_write_o;
  logic      remote_amo_o;
  word_t     remote_addr_o;
  word_t     remote_data_o;
  mask_t     remote_mask_o;
  reg_id_t   remote_rd_o;
  logic      reserve_valid_o;

  word_t lfsr_q = 32'h47c4f94f;
  word_t prefix = 32'h8000_0000;
  // expected contents of the local data memory
  word_t model [`LSU_DMEM_WORDS];

  mem_subsys_top i_dut (.*);

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // galois lfsr, one step per bit taken
  function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic compare_mask(input string name, input mask_t got, input mask_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic compare_rd(input string name, input reg_id_t got, input reg_id_t exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // byte lanes touched by an access of this size
  function automatic mask_t lanes(input word_t addr, input mem_size_e size);
    case (size)
      SIZE_BYTE: return mask_t'(4'b0001 << addr[1:0]);
      SIZE_HALF: return addr[1] ? 4'b1100 : 4'b0011;
      default:   return 4'b1111;
    endcase
  endfunction

  function automatic word_t replicate(input word_t data, input mem_size_e size);
    case (size)
      SIZE_BYTE: return {4{data[7:0]}};
      SIZE_HALF: return {2{data[15:0]}};
      default:   return data;
    endcase
  endfunction

  function automatic word_t model_load(input word_t addr, input mem_size_e size, input logic uns);
    word_t      w;
    logic [7:0] b;
    logic [15:0] h;
    w = model[addr[11:2]];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (size)
      SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default:   return w;
    endcase
  endfunction

  function automatic rreq_t remote_expect(input mem_op_e op, input mem_size_e size,
                                          input word_t addr, input word_t data,
                                          input reg_id_t rd);
    return {addr, replicate(data, size), lanes(addr, size), op == MEM_STORE,
            op == MEM_AMO, rd};
  endfunction

  // base register is chosen so that base plus offset hits addr
  task automatic present(input mem_op_e op, input mem_size_e size, input logic uns,
                         input word_t addr, input word_t data, input reg_id_t rd);
    imm_t off;
    off         = imm_t'(rand_bits(12));
    op_i        = op;
    size_i      = size;
    unsigned_i  = uns;
    offset_i    = off;
    rs1_i       = addr - {{20{off[11]}}, off};
    rs2_i       = data;
    rd_i        = rd;
    req_valid_i = 1'b1;
  endtask

  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = req_ready_o;
      @(posedge clk_i);
    end
    #1;
    req_valid_i   = 1'b0;
    icache_miss_i = 1'b0;
  endtask

  task automatic send(input mem_op_e op, input mem_size_e size, input logic uns,
                      input word_t addr, input word_t data, input reg_id_t rd);
    present(op, size, uns, addr, data, rd);
    wait_accept();
  endtask

  task automatic do_store(input word_t addr, input mem_size_e size, input word_t data);
    mask_t m;
    word_t r;
    send(MEM_STORE, size, 1'b0, addr, data, reg_id_t'(rand_bits(5)));
    m = lanes(addr, size);
    r = replicate(data, size);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) model[addr[11:2]][8*b +: 8] = r[8*b +: 8];
    end
  endtask

  // result must be there in the cycle after acceptance
  task automatic check_load(input word_t addr, input mem_size_e size, input logic uns);
    reg_id_t rd;
    rd = reg_id_t'(rand_bits(5));
    send(MEM_LOAD, size, uns, addr, 32'h0, rd);
    compare_flag("load_valid_o", load_valid_o, 1'b1);
    compare_word("load_data_o", load_data_o, model_load(addr, size, uns));
    compare_rd("load_rd_o", load_rd_o, rd);
  endtask

  task automatic write_cfg(input logic sel, input word_t data);
    cfg_we_i   = 1'b1;
    cfg_sel_i  = sel;
    cfg_data_i = data;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic pop_remote(output rreq_t got);
    logic seen;
    seen           = 1'b0;
    remote_ready_i = 1'b1;
    while (!seen) begin
      @(negedge clk_i);
      seen = remote_valid_o;
      got  = {remote_addr_o, remote_data_o, remote_mask_o, remote_write_o,
              remote_amo_o, remote_rd_o};
      @(posedge clk_i);
    end
    #1;
    remote_ready_i = 1'b0;
  endtask

  task automatic check_remote(input rreq_t exp);
    rreq_t got;
    pop_remote(got);
    compare_word("remote_addr_o", got.addr, exp.addr);
    compare_word("remote_data_o", got.data, exp.data);
    compare_mask("remote_mask_o", got.mask, exp.mask);
    compare_flag("remote_write_o", got.write, exp.write);
    compare_flag("remote_amo_o", got.amo, exp.amo);
    compare_rd("remote_rd_o", got.rd, exp.rd);
  endtask

  task automatic test_word_store_load();
    word_t addrs [8];
    for (int i = 0; i < 8; i++) begin
      addrs[i] = rand_bits(10) << 2;
      do_store(addrs[i], SIZE_WORD, rand_bits(32));
    end
    for (int i = 0; i < 8; i++) begin
      check_load(addrs[i], SIZE_WORD, 1'b0);
    end
  endtask

  task automatic test_subword();
    word_t base;
    word_t boff;
    word_t hoff;
    for (int r = 0; r < 4; r++) begin
      base = rand_bits(10) << 2;
      do_store(base, SIZE_WORD, rand_bits(32));
      if (r[0]) do_store(base | (rand_bits(1) << 1), SIZE_HALF, rand_bits(32));
      else do_store(base | rand_bits(2), SIZE_BYTE, rand_bits(32));
      boff = base | rand_bits(2);
      hoff = base | (rand_bits(1) << 1);
      check_load(boff, SIZE_BYTE, 1'b0);
      check_load(boff, SIZE_BYTE, 1'b1);
      check_load(hoff, SIZE_HALF, 1'b0);
      check_load(hoff, SIZE_HALF, 1'b1);
      check_load(base, SIZE_WORD, 1'b0);
    end
  endtask

  // third request must stall until the full queue drains
  task automatic test_remote_routing();
    rreq_t     exp_q [$];
    word_t     addr;
    word_t     data;
    reg_id_t   rd;
    mem_op_e   op;
    mem_size_e size;
    for (int i = 0; i < 3; i++) begin
      op   = (i == 0) ? MEM_STORE : ((i == 1) ? MEM_LOAD : MEM_AMO);
      size = (i == 0) ? SIZE_BYTE : ((i == 1) ? SIZE_HALF : SIZE_WORD);
      addr = 32'h0004_0000 + rand_bits(16);
      if (size == SIZE_HALF) addr[0] = 1'b0;
      if (size == SIZE_WORD) addr[1:0] = 2'b00;
      data = rand_bits(32);
      rd   = reg_id_t'(rand_bits(5));
      exp_q.push_back(remote_expect(op, size, addr, data, rd));
      present(op, size, 1'b0, addr, data, rd);
      if (i < 2) wait_accept();
    end
    repeat (3) begin
      @(negedge clk_i);
      compare_flag("req_ready_o", req_ready_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
    fork
      wait_accept();
      repeat (3) check_remote(exp_q.pop_front());
    join
    @(negedge clk_i);
    compare_flag("remote_valid_o", remote_valid_o, 1'b0);
    @(posedge clk_i);
    #1;
  endtask

  task automatic test_icache_miss();
    word_t   pc;
    reg_id_t rd;
    rreq_t   got;
    for (int i = 0; i < 2; i++) begin
      if (i == 1) begin
        prefix = rand_bits(32);
        write_cfg(1'b0, prefix);
      end
      pc            = rand_bits(32);
      rd            = reg_id_t'(rand_bits(5));
      icache_miss_i = 1'b1;
      pc_plus4_i    = pc;
      send(MEM_LOAD, SIZE_WORD, 1'b0, 32'h0, 32'h0, rd);
      pop_remote(got);
      compare_word("remote_addr_o", got.addr, (pc - 32'd4) | prefix);
      compare_rd("remote_rd_o", got.rd, rd);
    end
  endtask

  task automatic test_reservation();
    word_t addr;
    addr = rand_bits(10) << 2;
    do_store(addr, SIZE_WORD, rand_bits(32));
    send(MEM_LR, SIZE_WORD, 1'b0, addr, 32'h0, reg_id_t'(rand_bits(5)));
    compare_flag("reserve_valid_o", reserve_valid_o, 1'b1);
    compare_word("load_data_o", load_data_o, model_load(addr, SIZE_WORD, 1'b0));
    do_store(addr ^ 32'h4, SIZE_WORD, rand_bits(32));
    compare_flag("reserve_valid_o", reserve_valid_o, 1'b1);
    do_store(addr | 32'h1, SIZE_BYTE, rand_bits(32));
    compare_flag("reserve_valid_o", reserve_valid_o, 1'b0);
  endtask

  task automatic test_remote_disable();
    write_cfg(1'b1, 32'h0);
    send(MEM_STORE, SIZE_WORD, 1'b0, 32'h0008_0000 + (rand_bits(12) << 2),
         rand_bits(32), reg_id_t'(rand_bits(5)));
    send(MEM_LOAD, SIZE_WORD, 1'b0, 32'h0008_0000, 32'h0, reg_id_t'(rand_bits(5)));
    repeat (4) begin
      @(negedge clk_i);
      compare_flag("remote_valid_o", remote_valid_o, 1'b0);
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    #(test_ops_lp * 20 * clk_period_lp);
    fail_run("watchdog expired before all tests completed");
  end

  initial begin
    reset_i        = 1'b0;
    req_valid_i    = 1'b0;
    op_i           = MEM_LOAD;
    size_i         = SIZE_WORD;
    unsigned_i     = 1'b0;
    rs1_i          = '0;
    rs2_i          = '0;
    offset_i       = '0;
    rd_i           = '0;
    icache_miss_i  = 1'b0;
    pc_plus4_i     = '0;
    cfg_we_i       = 1'b0;
    cfg_sel_i      = 1'b0;
    cfg_data_i     = '0;
    remote_ready_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b1;
    compare_flag("remote_valid_o", remote_valid_o, 1'b0);
    compare_flag("load_valid_o", load_valid_o, 1'b0);
    compare_flag("reserve_valid_o", reserve_valid_o, 1'b0);
    test_icache_miss();
    test_word_store_load();
    test_subword();
    test_remote_routing();
    test_reservation();
    test_remote_disable();
    $display("NO ERRORS");
    $finish;
  end

endmodule
